// ==== riscv_core.f ====
riscv_pkg.sv
riscv_ctrl.sv
riscv_hazard.sv
riscv_regfile.sv
riscv_estage.sv
riscv_datapath.sv
riscv_core_top.sv
riscv_core_tb.sv

// ==== riscv_core_tb.sv ====
`timescale 1ns/1ns

module riscv_core_tb;
  import riscv_pkg::*;

  localparam int XLEN           = riscv_pkg::XLEN;
  localparam int IMEM_WORDS     = 256;
  localparam int DMEM_WORDS     = 128;
  localparam int PROG_LEN       = 42;
  localparam int MAX_STEPS      = 200;   // reference stops at the halt loop long before this
  localparam int DRAIN_CYCLES   = 8;
  localparam int TIMEOUT_CYCLES = 8 * PROG_LEN + 50;

  logic  clk;
  logic  rst_n;
  xlen_t imem_addr;
  inst_t imem_inst;
  xlen_t dmem_addr;
  xlen_t dmem_wdata;
  logic  dmem_we;
  xlen_t dmem_rdata;

  inst_t imem [IMEM_WORDS];
  xlen_t dmem [DMEM_WORDS];
  xlen_t exp_addr[$];
  xlen_t exp_data[$];
  int    store_idx = 0;
  int    cycle_cnt = 0;

  riscv_core_top #(.XLEN(XLEN)) UUT (
    .i_core_clk   (clk),
    .i_rst_n      (rst_n),
    .o_imem_addr  (imem_addr),
    .i_imem_inst  (imem_inst),
    .o_dmem_addr  (dmem_addr),
    .o_dmem_wdata (dmem_wdata),
    .o_dmem_we    (dmem_we),
    .i_dmem_rdata (dmem_rdata)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  assign imem_inst  = imem[imem_addr[9:2]];   // same-cycle fetch
  assign dmem_rdata = dmem[dmem_addr[9:3]];

  always @(posedge clk) begin
    if (dmem_we === 1'b1) begin
      dmem[dmem_addr[9:3]] <= dmem_wdata;
    end
  end

  function automatic inst_t op_inst(int f7_5, int rs2, int rs1, int f3, int rd);
    return {1'b0, 1'(f7_5), 5'b0, 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), OPC_OP};
  endfunction

  function automatic inst_t imm_inst(opcode_e op, int imm, int rs1, int f3, int rd);
    return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), op};
  endfunction

  function automatic inst_t store_inst(int imm, int rs2, int rs1);
    logic [11:0] im;
    im = 12'(imm);
    return {im[11:5], 5'(rs2), 5'(rs1), F3_DOUBLE, im[4:0], OPC_STORE};
  endfunction

  function automatic inst_t branch_inst(int off, int rs2, int rs1, int f3);
    logic [12:0] o;
    o = 13'(off);
    return {o[12], o[10:5], 5'(rs2), 5'(rs1), 3'(f3), o[4:1], o[11], OPC_BRANCH};
  endfunction

  function automatic inst_t jal_inst(int off, int rd);
    logic [20:0] o;
    o = 21'(off);
    return {o[20], o[10:1], o[11], o[19:12], 5'(rd), OPC_JAL};
  endfunction

  // odd multiplier spreads every address bit over the word
  function automatic xlen_t fill_word(int idx);
    return xlen_t'(idx) * 64'h9e37_79b9_7f4a_7c15 + 64'h0123_4567_89ab_cdef;
  endfunction

  task automatic load_program();
    int r_lui;
    int r_a;
    int r_b;
    int r_c;
    int r_d;
    int r_e;
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = NOP_INST;
    end
    r_lui = int'($urandom & 32'h000f_ffff);
    r_a   = int'($urandom & 32'h0000_0fff);
    r_b   = int'($urandom & 32'h0000_0fff);
    r_c   = int'($urandom & 32'h0000_0fff);
    r_d   = int'($urandom & 32'h0000_0fff);
    r_e   = int'($urandom & 32'h0000_0fff);
    imem[0]  = imm_inst(OPC_OP_IMM, 256, 0, 0, 1);    // x1 = store base
    imem[1]  = {20'(r_lui), 5'd2, OPC_LUI};
    imem[2]  = imm_inst(OPC_OP_IMM, r_a, 2, 0, 2);    // uses x2 from memory stage
    imem[3]  = imm_inst(OPC_OP_IMM, r_b, 0, 0, 3);
    imem[4]  = op_inst(0, 3, 2, 0, 4);                // add x4
    imem[5]  = op_inst(1, 3, 4, 0, 5);                // sub x5
    imem[6]  = op_inst(0, 5, 4, 7, 6);                // and x6
    imem[7]  = op_inst(0, 2, 6, 6, 7);                // or x7
    imem[8]  = op_inst(0, 3, 7, 4, 8);                // xor x8
    imem[9]  = op_inst(0, 2, 3, 2, 9);                // slt x9
    imem[10] = op_inst(0, 3, 2, 2, 10);               // slt x10
    for (int i = 0; i < 7; i++) begin
      imem[11 + i] = store_inst(8 * i, 4 + i, 1);
    end
    imem[18] = store_inst(56, 2, 1);
    imem[19] = imm_inst(OPC_OP_IMM, r_c, 0, 0, 11);
    imem[20] = imm_inst(OPC_OP_IMM, r_d, 0, 0, 13);
    imem[21] = imm_inst(OPC_OP_IMM, r_e, 0, 0, 14);
    imem[22] = op_inst(0, 13, 11, 0, 12);             // x11 via regfile bypass, x13 from wb
    imem[23] = store_inst(64, 12, 1);
    imem[24] = imm_inst(OPC_OP_IMM, r_e, 3, 0, 0);    // write to x0 is dropped
    imem[25] = store_inst(72, 0, 1);
    imem[26] = imm_inst(OPC_LOAD, 0, 1, 3, 16);
    imem[27] = op_inst(0, 3, 16, 0, 17);              // load-use stall
    imem[28] = store_inst(80, 17, 1);
    imem[29] = imm_inst(OPC_LOAD, 200, 1, 3, 18);     // preloaded word
    imem[30] = op_inst(0, 18, 18, 0, 19);
    imem[31] = store_inst(88, 19, 1);
    imem[32] = branch_inst(12, 4, 4, 0);              // beq taken
    imem[33] = store_inst(96, 3, 1);
    imem[34] = store_inst(104, 2, 1);
    imem[35] = branch_inst(12, 4, 4, 1);              // bne not taken
    imem[36] = store_inst(112, 0, 1);                 // x0 read back from the regfile
    imem[37] = jal_inst(12, 20);
    imem[38] = store_inst(120, 2, 1);
    imem[39] = store_inst(128, 3, 1);
    imem[40] = store_inst(136, 20, 1);                // link value
    imem[41] = jal_inst(0, 0);                        // halt loop
  endtask

  // instruction-level model of the subset
  function automatic void compute_expected_stores();
    xlen_t       regs [32];
    xlen_t       mem [DMEM_WORDS];
    xlen_t       pc;
    xlen_t       next_pc;
    xlen_t       a;
    xlen_t       b;
    xlen_t       addr;
    inst_t       inst;
    logic [4:0]  rd;
    logic [2:0]  f3;
    int          step;
    logic        done;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      mem[i] = fill_word(i);
    end
    pc   = '0;
    step = 0;
    done = 1'b0;
    while (!done && step < MAX_STEPS) begin
      inst    = imem[pc[9:2]];
      rd      = inst[11:7];
      f3      = inst[14:12];
      a       = regs[inst[19:15]];
      b       = regs[inst[24:20]];
      next_pc = pc + xlen_t'(4);
      case (inst[6:0])
        OPC_OP: begin
          case (f3)
            3'b000:  regs[rd] = inst[30] ? a - b : a + b;
            3'b010:  regs[rd] = ($signed(a) < $signed(b)) ? xlen_t'(1) : '0;
            3'b100:  regs[rd] = a ^ b;
            3'b110:  regs[rd] = a | b;
            default: regs[rd] = a & b;
          endcase
        end
        OPC_OP_IMM: regs[rd] = a + xlen_t'(signed'(inst[31:20]));
        OPC_LUI:    regs[rd] = xlen_t'(signed'({inst[31:12], 12'b0}));
        OPC_LOAD: begin
          addr     = a + xlen_t'(signed'(inst[31:20]));
          regs[rd] = mem[addr[9:3]];
        end
        OPC_STORE: begin
          addr = a + xlen_t'(signed'({inst[31:25], inst[11:7]}));
          mem[addr[9:3]] = b;
          exp_addr.push_back(addr);
          exp_data.push_back(b);
        end
        OPC_BRANCH: begin
          if ((a == b) == (f3 == 3'b000)) begin
            next_pc = pc + xlen_t'(signed'({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
          end
        end
        OPC_JAL: begin
          regs[rd] = pc + xlen_t'(4);
          next_pc  = pc + xlen_t'(signed'({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}));
          done     = (next_pc == pc);                 // jump to self ends the program
        end
        default: ;
      endcase
      regs[0] = '0;
      pc      = next_pc;
      step++;
    end
  endfunction

  task automatic check_value(input xlen_t got, input xlen_t exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "check failed");
    end
  endtask

  // write enable held low through reset
  always @(negedge clk) begin
    if (!rst_n) begin
      check_value(xlen_t'(dmem_we), '0, "o_dmem_we during reset");
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      if (dmem_we === 1'b1) begin
        if (store_idx >= exp_addr.size()) begin
          $display("unexpected store to %h at %0t ns after the last expected store",
                   dmem_addr, $time);
          $display("TEST RESULT: FAIL");
          $fatal(1, "extra store");
        end else begin
          check_value(dmem_addr, exp_addr[store_idx], $sformatf("store %0d address", store_idx));
          check_value(dmem_wdata, exp_data[store_idx], $sformatf("store %0d data", store_idx));
          store_idx++;
        end
      end else if (dmem_we !== 1'b0) begin
        $display("o_dmem_we is unknown at %0t ns", $time);
        $display("TEST RESULT: FAIL");
        $fatal(1, "unknown write enable");
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles with %0d of %0d stores seen", cycle_cnt, store_idx,
               exp_addr.size());
      $display("TEST RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

  initial begin
    rst_n = 1'b0;
    void'($urandom(32'ha5c0));
    load_program();
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] <= fill_word(i);
    end
    compute_expected_stores();
    repeat (16) @(posedge clk);
    #5 rst_n = 1'b1;
    while (store_idx < exp_addr.size()) begin
      @(negedge clk);
    end
    repeat (DRAIN_CYCLES) @(negedge clk);   // any wrong-path store would show here
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// ==== riscv_core_top.sv ====
`timescale 1ns/1ns

module riscv_core_top #(
  parameter int XLEN = riscv_pkg::XLEN
) (
  input  logic             i_core_clk,
  input  logic             i_rst_n,
  output logic [XLEN-1:0]  o_imem_addr,   // fetch pc
  input  riscv_pkg::inst_t i_imem_inst,   // same-cycle read
  output logic [XLEN-1:0]  o_dmem_addr,
  output logic [XLEN-1:0]  o_dmem_wdata,
  output logic             o_dmem_we,     // write at the rising edge
  input  logic [XLEN-1:0]  i_dmem_rdata
);
  import riscv_pkg::*;

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic        funct7_5;
  logic        regw;
  logic        memw;
  logic        jump;
  logic        branch;
  logic        bne;
  logic        asel;
  logic        bsel;
  alu_op_e     aluop;
  result_sel_e resultsel;
  imm_sel_e    immsel;
  regaddr_t    rs1addr_d;
  regaddr_t    rs2addr_d;
  regaddr_t    rs1addr_e;
  regaddr_t    rs2addr_e;
  regaddr_t    rdaddr_e;
  result_sel_e resultsel_e;
  logic        pcsrc_e;
  regaddr_t    rdaddr_m;
  logic        regw_m;
  regaddr_t    rdaddr_wb;
  logic        regw_wb;
  fwd_sel_e    fwda;
  fwd_sel_e    fwdb;
  logic        stallpc;
  logic        stall_fd;
  logic        flush_fd;
  logic        flush_de;

  riscv_ctrl u_riscv_ctrl (
    .i_ctrl_opcode    (opcode),
    .i_ctrl_funct3    (funct3),
    .i_ctrl_funct7_5  (funct7_5),
    .o_ctrl_regw      (regw),
    .o_ctrl_memw      (memw),
    .o_ctrl_jump      (jump),
    .o_ctrl_branch    (branch),
    .o_ctrl_bne       (bne),
    .o_ctrl_asel      (asel),
    .o_ctrl_bsel      (bsel),
    .o_ctrl_aluop     (aluop),
    .o_ctrl_resultsel (resultsel),
    .o_ctrl_immsel    (immsel)
  );

  riscv_hazard u_riscv_hazard (
    .i_hz_rs1addr_d   (rs1addr_d),
    .i_hz_rs2addr_d   (rs2addr_d),
    .i_hz_rs1addr_e   (rs1addr_e),
    .i_hz_rs2addr_e   (rs2addr_e),
    .i_hz_rdaddr_e    (rdaddr_e),
    .i_hz_resultsel_e (resultsel_e),
    .i_hz_pcsrc_e     (pcsrc_e),
    .i_hz_rdaddr_m    (rdaddr_m),
    .i_hz_regw_m      (regw_m),
    .i_hz_rdaddr_wb   (rdaddr_wb),
    .i_hz_regw_wb     (regw_wb),
    .o_hz_fwda        (fwda),
    .o_hz_fwdb        (fwdb),
    .o_hz_stallpc     (stallpc),
    .o_hz_stall_fd    (stall_fd),
    .o_hz_flush_fd    (flush_fd),
    .o_hz_flush_de    (flush_de)
  );

  riscv_datapath #(.XLEN(XLEN)) u_riscv_datapath (
    .i_dp_clk         (i_core_clk),
    .i_rst_n          (i_rst_n),
    .i_dp_stallpc     (stallpc),
    .i_dp_stall_fd    (stall_fd),
    .i_dp_flush_fd    (flush_fd),
    .i_dp_flush_de    (flush_de),
    .i_dp_inst        (i_imem_inst),
    .i_dp_regw        (regw),
    .i_dp_memw        (memw),
    .i_dp_jump        (jump),
    .i_dp_branch      (branch),
    .i_dp_bne         (bne),
    .i_dp_asel        (asel),
    .i_dp_bsel        (bsel),
    .i_dp_aluop       (aluop),
    .i_dp_resultsel   (resultsel),
    .i_dp_immsel      (immsel),
    .i_dp_fwda        (fwda),
    .i_dp_fwdb        (fwdb),
    .i_dp_dm_rdata    (i_dmem_rdata),
    .o_dp_pc          (o_imem_addr),
    .o_dp_opcode      (opcode),
    .o_dp_funct3      (funct3),
    .o_dp_funct7_5    (funct7_5),
    .o_dp_rs1addr_d   (rs1addr_d),
    .o_dp_rs2addr_d   (rs2addr_d),
    .o_dp_rs1addr_e   (rs1addr_e),
    .o_dp_rs2addr_e   (rs2addr_e),
    .o_dp_rdaddr_e    (rdaddr_e),
    .o_dp_resultsel_e (resultsel_e),
    .o_dp_pcsrc_e     (pcsrc_e),
    .o_dp_rdaddr_m    (rdaddr_m),
    .o_dp_regw_m      (regw_m),
    .o_dp_rdaddr_wb   (rdaddr_wb),
    .o_dp_regw_wb     (regw_wb),
    .o_dp_dm_addr     (o_dmem_addr),
    .o_dp_dm_wdata    (o_dmem_wdata),
    .o_dp_dm_we       (o_dmem_we)
  );

endmodule

// ==== riscv_ctrl.sv ====
`timescale 1ns/1ns

module riscv_ctrl (
  input  logic [6:0]             i_ctrl_opcode,
  input  logic [2:0]             i_ctrl_funct3,
  input  logic                   i_ctrl_funct7_5,
  output logic                   o_ctrl_regw,      // to de register
  output logic                   o_ctrl_memw,
  output logic                   o_ctrl_jump,
  output logic                   o_ctrl_branch,
  output logic                   o_ctrl_bne,       // invert the equality test
  output logic                   o_ctrl_asel,      // 1 selects pc as operand a
  output logic                   o_ctrl_bsel,      // 1 selects immediate as operand b
  output riscv_pkg::alu_op_e     o_ctrl_aluop,
  output riscv_pkg::result_sel_e o_ctrl_resultsel,
  output riscv_pkg::imm_sel_e    o_ctrl_immsel
);
  import riscv_pkg::*;

  alu_op_e op_aluop;

  // funct7 bit 5 only matters for register operands
  always_comb begin
    case (i_ctrl_funct3)
      F3_ADD_SUB: op_aluop = i_ctrl_funct7_5 ? ALU_SUB : ALU_ADD;
      F3_SLT:     op_aluop = ALU_SLT;
      F3_XOR:     op_aluop = ALU_XOR;
      F3_OR:      op_aluop = ALU_OR;
      F3_AND:     op_aluop = ALU_AND;
      default:    op_aluop = ALU_ADD;
    endcase
  end

  always_comb begin
    o_ctrl_regw      = 1'b0;     // unknown opcode is a no-op
    o_ctrl_memw      = 1'b0;
    o_ctrl_jump      = 1'b0;
    o_ctrl_branch    = 1'b0;
    o_ctrl_bne       = 1'b0;
    o_ctrl_asel      = 1'b0;
    o_ctrl_bsel      = 1'b0;
    o_ctrl_aluop     = ALU_ADD;
    o_ctrl_resultsel = RES_ALU;
    o_ctrl_immsel    = IMM_I;
    case (i_ctrl_opcode)
      OPC_OP: begin
        o_ctrl_regw  = 1'b1;
        o_ctrl_aluop = op_aluop;
      end
      OPC_OP_IMM: begin
        o_ctrl_regw = 1'b1;         // addi only
        o_ctrl_bsel = 1'b1;
      end
      OPC_LUI: begin
        o_ctrl_regw   = 1'b1;
        o_ctrl_bsel   = 1'b1;
        o_ctrl_aluop  = ALU_PASS_B;
        o_ctrl_immsel = IMM_U;
      end
      OPC_LOAD: begin
        o_ctrl_regw      = 1'b1;
        o_ctrl_bsel      = 1'b1;
        o_ctrl_resultsel = RES_MEM;
      end
      OPC_STORE: begin
        o_ctrl_memw   = 1'b1;
        o_ctrl_bsel   = 1'b1;
        o_ctrl_immsel = IMM_S;
      end
      OPC_BRANCH: begin
        o_ctrl_branch = 1'b1;
        o_ctrl_bne    = (i_ctrl_funct3 == F3_BNE);
        o_ctrl_asel   = 1'b1;
        o_ctrl_bsel   = 1'b1;
        o_ctrl_immsel = IMM_B;
      end
      OPC_JAL: begin
        o_ctrl_regw      = 1'b1;
        o_ctrl_jump      = 1'b1;
        o_ctrl_asel      = 1'b1;
        o_ctrl_bsel      = 1'b1;
        o_ctrl_resultsel = RES_PC4;  // link value
        o_ctrl_immsel    = IMM_J;
      end
      default: ;
    endcase
  end

endmodule

// ==== riscv_datapath.sv ====
`timescale 1ns/1ns

module riscv_datapath #(
  parameter int XLEN = riscv_pkg::XLEN
) (
  input  logic                   i_dp_clk,
  input  logic                   i_rst_n,
  input  logic                   i_dp_stallpc,    // from hazard unit
  input  logic                   i_dp_stall_fd,
  input  logic                   i_dp_flush_fd,
  input  logic                   i_dp_flush_de,
  input  riscv_pkg::inst_t       i_dp_inst,       // from instruction memory
  input  logic                   i_dp_regw,       // decode controls from ctrl
  input  logic                   i_dp_memw,
  input  logic                   i_dp_jump,
  input  logic                   i_dp_branch,
  input  logic                   i_dp_bne,
  input  logic                   i_dp_asel,
  input  logic                   i_dp_bsel,
  input  riscv_pkg::alu_op_e     i_dp_aluop,
  input  riscv_pkg::result_sel_e i_dp_resultsel,
  input  riscv_pkg::imm_sel_e    i_dp_immsel,
  input  riscv_pkg::fwd_sel_e    i_dp_fwda,
  input  riscv_pkg::fwd_sel_e    i_dp_fwdb,
  input  logic [XLEN-1:0]        i_dp_dm_rdata,   // from data memory
  output logic [XLEN-1:0]        o_dp_pc,         // to instruction memory
  output logic [6:0]             o_dp_opcode,     // to ctrl
  output logic [2:0]             o_dp_funct3,
  output logic                   o_dp_funct7_5,
  output riscv_pkg::regaddr_t    o_dp_rs1addr_d,  // to hazard unit
  output riscv_pkg::regaddr_t    o_dp_rs2addr_d,
  output riscv_pkg::regaddr_t    o_dp_rs1addr_e,
  output riscv_pkg::regaddr_t    o_dp_rs2addr_e,
  output riscv_pkg::regaddr_t    o_dp_rdaddr_e,
  output riscv_pkg::result_sel_e o_dp_resultsel_e,
  output logic                   o_dp_pcsrc_e,
  output riscv_pkg::regaddr_t    o_dp_rdaddr_m,
  output logic                   o_dp_regw_m,
  output riscv_pkg::regaddr_t    o_dp_rdaddr_wb,
  output logic                   o_dp_regw_wb,
  output logic [XLEN-1:0]        o_dp_dm_addr,    // to data memory
  output logic [XLEN-1:0]        o_dp_dm_wdata,
  output logic                   o_dp_dm_we
);
  import riscv_pkg::*;

  logic [XLEN-1:0] pcplus4_f;
  inst_t           inst_d;
  logic [XLEN-1:0] pc_d;
  logic [XLEN-1:0] pcplus4_d;
  logic [XLEN-1:0] imm_d;
  logic [XLEN-1:0] rs1data_d;
  logic [XLEN-1:0] rs2data_d;
  logic [XLEN-1:0] pc_e;
  logic [XLEN-1:0] pcplus4_e;
  logic [XLEN-1:0] rs1data_e;
  logic [XLEN-1:0] rs2data_e;
  logic [XLEN-1:0] imm_e;
  logic            regw_e;
  logic            memw_e;
  logic            jump_e;
  logic            branch_e;
  logic            bne_e;
  logic            asel_e;
  logic            bsel_e;
  alu_op_e         aluop_e;
  logic [XLEN-1:0] aluresult_e;
  logic [XLEN-1:0] storedata_e;
  logic [XLEN-1:0] target_e;
  logic            branchtaken_e;
  result_sel_e     resultsel_m;
  logic [XLEN-1:0] pcplus4_m;
  logic [XLEN-1:0] rddata_m;
  result_sel_e     resultsel_wb;
  logic [XLEN-1:0] aluresult_wb;
  logic [XLEN-1:0] memload_wb;
  logic [XLEN-1:0] pcplus4_wb;
  logic [XLEN-1:0] rddata_wb;

  assign pcplus4_f    = o_dp_pc + XLEN'(4);
  assign o_dp_pcsrc_e = jump_e | branchtaken_e;

  always_ff @(posedge i_dp_clk) begin
    if (!i_rst_n) begin
      o_dp_pc <= '0;
    end else if (o_dp_pcsrc_e) begin
      o_dp_pc <= target_e;       // redirect from execute
    end else if (!i_dp_stallpc) begin
      o_dp_pc <= pcplus4_f;
    end
  end

  always_ff @(posedge i_dp_clk) begin
    if (!i_rst_n || i_dp_flush_fd) begin
      inst_d <= NOP_INST;        // bubble
    end else if (!i_dp_stall_fd) begin
      inst_d <= i_dp_inst;
    end
  end

  always_ff @(posedge i_dp_clk) begin
    if (!i_dp_stall_fd) begin
      pc_d      <= o_dp_pc;
      pcplus4_d <= pcplus4_f;
    end
  end

  assign o_dp_opcode    = inst_d[6:0];
  assign o_dp_funct3    = inst_d[14:12];
  assign o_dp_funct7_5  = inst_d[30];
  assign o_dp_rs1addr_d = inst_d[19:15];
  assign o_dp_rs2addr_d = inst_d[24:20];

  always_comb begin
    case (i_dp_immsel)
      IMM_S:   imm_d = {{(XLEN-12){inst_d[31]}}, inst_d[31:25], inst_d[11:7]};
      IMM_B:   imm_d = {{(XLEN-13){inst_d[31]}}, inst_d[31], inst_d[7], inst_d[30:25],
                        inst_d[11:8], 1'b0};
      IMM_U:   imm_d = {{(XLEN-32){inst_d[31]}}, inst_d[31:12], 12'b0};
      IMM_J:   imm_d = {{(XLEN-21){inst_d[31]}}, inst_d[31], inst_d[19:12], inst_d[20],
                        inst_d[30:21], 1'b0};
      default: imm_d = {{(XLEN-12){inst_d[31]}}, inst_d[31:20]};
    endcase
  end

  riscv_regfile #(.XLEN(XLEN)) u_riscv_regfile (
    .i_rf_clk     (i_dp_clk),
    .i_rst_n      (i_rst_n),
    .i_rf_rs1addr (o_dp_rs1addr_d),
    .i_rf_rs2addr (o_dp_rs2addr_d),
    .i_rf_we      (o_dp_regw_wb),
    .i_rf_rdaddr  (o_dp_rdaddr_wb),
    .i_rf_rddata  (rddata_wb),
    .o_rf_rs1data (rs1data_d),
    .o_rf_rs2data (rs2data_d)
  );

  // de register, controls cleared on flush
  always_ff @(posedge i_dp_clk) begin
    if (!i_rst_n || i_dp_flush_de) begin
      regw_e           <= 1'b0;
      memw_e           <= 1'b0;
      jump_e           <= 1'b0;
      branch_e         <= 1'b0;
      o_dp_resultsel_e <= RES_ALU;  // keeps a stale load from stalling
    end else begin
      regw_e           <= i_dp_regw;
      memw_e           <= i_dp_memw;
      jump_e           <= i_dp_jump;
      branch_e         <= i_dp_branch;
      o_dp_resultsel_e <= i_dp_resultsel;
    end
  end

  always_ff @(posedge i_dp_clk) begin
    pc_e           <= pc_d;
    pcplus4_e      <= pcplus4_d;
    rs1data_e      <= rs1data_d;
    rs2data_e      <= rs2data_d;
    imm_e          <= imm_d;
    o_dp_rs1addr_e <= o_dp_rs1addr_d;
    o_dp_rs2addr_e <= o_dp_rs2addr_d;
    o_dp_rdaddr_e  <= inst_d[11:7];
    bne_e          <= i_dp_bne;
    asel_e         <= i_dp_asel;
    bsel_e         <= i_dp_bsel;
    aluop_e        <= i_dp_aluop;
  end

  riscv_estage #(.XLEN(XLEN)) u_riscv_estage (
    .i_es_rs1data     (rs1data_e),
    .i_es_rs2data     (rs2data_e),
    .i_es_fwda        (i_dp_fwda),
    .i_es_fwdb        (i_dp_fwdb),
    .i_es_rddata_m    (rddata_m),
    .i_es_rddata_wb   (rddata_wb),
    .i_es_asel        (asel_e),
    .i_es_bsel        (bsel_e),
    .i_es_pc          (pc_e),
    .i_es_imm         (imm_e),
    .i_es_aluop       (aluop_e),
    .i_es_branch      (branch_e),
    .i_es_bne         (bne_e),
    .o_es_aluresult   (aluresult_e),
    .o_es_storedata   (storedata_e),
    .o_es_branchtaken (branchtaken_e),
    .o_es_target      (target_e)
  );

  always_ff @(posedge i_dp_clk) begin
    if (!i_rst_n) begin
      o_dp_regw_m <= 1'b0;
      o_dp_dm_we  <= 1'b0;
      resultsel_m <= RES_ALU;
    end else begin
      o_dp_regw_m <= regw_e;
      o_dp_dm_we  <= memw_e;
      resultsel_m <= o_dp_resultsel_e;
    end
  end

  always_ff @(posedge i_dp_clk) begin
    o_dp_dm_addr  <= aluresult_e;
    o_dp_dm_wdata <= storedata_e;
    o_dp_rdaddr_m <= o_dp_rdaddr_e;
    pcplus4_m     <= pcplus4_e;
  end

  // jal link value must forward as pc+4
  assign rddata_m = (resultsel_m == RES_PC4) ? pcplus4_m : o_dp_dm_addr;

  always_ff @(posedge i_dp_clk) begin
    if (!i_rst_n) begin
      o_dp_regw_wb <= 1'b0;
      resultsel_wb <= RES_ALU;
    end else begin
      o_dp_regw_wb <= o_dp_regw_m;
      resultsel_wb <= resultsel_m;
    end
  end

  always_ff @(posedge i_dp_clk) begin
    aluresult_wb   <= o_dp_dm_addr;
    memload_wb     <= i_dp_dm_rdata;
    pcplus4_wb     <= pcplus4_m;
    o_dp_rdaddr_wb <= o_dp_rdaddr_m;
  end

  always_comb begin
    case (resultsel_wb)
      RES_MEM: rddata_wb = memload_wb;
      RES_PC4: rddata_wb = pcplus4_wb;
      default: rddata_wb = aluresult_wb;
    endcase
  end

endmodule

// ==== riscv_estage.sv ====
`timescale 1ns/1ns

module riscv_estage #(
  parameter int XLEN = riscv_pkg::XLEN
) (
  input  logic [XLEN-1:0]      i_es_rs1data,
  input  logic [XLEN-1:0]      i_es_rs2data,
  input  riscv_pkg::fwd_sel_e  i_es_fwda,
  input  riscv_pkg::fwd_sel_e  i_es_fwdb,
  input  logic [XLEN-1:0]      i_es_rddata_m,    // result sitting in memory stage
  input  logic [XLEN-1:0]      i_es_rddata_wb,   // result sitting in writeback
  input  logic                 i_es_asel,
  input  logic                 i_es_bsel,
  input  logic [XLEN-1:0]      i_es_pc,
  input  logic [XLEN-1:0]      i_es_imm,
  input  riscv_pkg::alu_op_e   i_es_aluop,
  input  logic                 i_es_branch,
  input  logic                 i_es_bne,
  output logic [XLEN-1:0]      o_es_aluresult,
  output logic [XLEN-1:0]      o_es_storedata,
  output logic                 o_es_branchtaken,
  output logic [XLEN-1:0]      o_es_target      // pc + imm for branch and jal
);
  import riscv_pkg::*;

  logic [XLEN-1:0] fwd_a;
  logic [XLEN-1:0] fwd_b;
  logic [XLEN-1:0] srca;
  logic [XLEN-1:0] srcb;
  logic            equal;

  function automatic logic [XLEN-1:0] fwd_mux(fwd_sel_e sel, logic [XLEN-1:0] reg_val,
                                              logic [XLEN-1:0] mem_val,
                                              logic [XLEN-1:0] wb_val);
    logic [XLEN-1:0] val;
    case (sel)
      FWD_MEM: val = mem_val;
      FWD_WB:  val = wb_val;
      default: val = reg_val;
    endcase
    return val;
  endfunction

  assign fwd_a = fwd_mux(i_es_fwda, i_es_rs1data, i_es_rddata_m, i_es_rddata_wb);
  assign fwd_b = fwd_mux(i_es_fwdb, i_es_rs2data, i_es_rddata_m, i_es_rddata_wb);

  assign srca = i_es_asel ? i_es_pc  : fwd_a;
  assign srcb = i_es_bsel ? i_es_imm : fwd_b;

  always_comb begin
    case (i_es_aluop)
      ALU_ADD:    o_es_aluresult = srca + srcb;
      ALU_SUB:    o_es_aluresult = srca - srcb;
      ALU_AND:    o_es_aluresult = srca & srcb;
      ALU_OR:     o_es_aluresult = srca | srcb;
      ALU_XOR:    o_es_aluresult = srca ^ srcb;
      ALU_SLT:    o_es_aluresult = {{(XLEN-1){1'b0}}, ($signed(srca) < $signed(srcb))};
      ALU_PASS_B: o_es_aluresult = srcb;
      default:    o_es_aluresult = '0;
    endcase
  end

  assign o_es_target      = i_es_pc + i_es_imm;  // own adder, alu stays free
  assign o_es_storedata   = fwd_b;               // sd data is forwarded rs2
  assign equal            = (fwd_a == fwd_b);
  assign o_es_branchtaken = i_es_branch & (equal ^ i_es_bne);

endmodule

// ==== riscv_hazard.sv ====
`timescale 1ns/1ns

module riscv_hazard (
  input  riscv_pkg::regaddr_t    i_hz_rs1addr_d,
  input  riscv_pkg::regaddr_t    i_hz_rs2addr_d,
  input  riscv_pkg::regaddr_t    i_hz_rs1addr_e,
  input  riscv_pkg::regaddr_t    i_hz_rs2addr_e,
  input  riscv_pkg::regaddr_t    i_hz_rdaddr_e,
  input  riscv_pkg::result_sel_e i_hz_resultsel_e, // load in execute when mem
  input  logic                   i_hz_pcsrc_e,
  input  riscv_pkg::regaddr_t    i_hz_rdaddr_m,
  input  logic                   i_hz_regw_m,
  input  riscv_pkg::regaddr_t    i_hz_rdaddr_wb,
  input  logic                   i_hz_regw_wb,
  output riscv_pkg::fwd_sel_e    o_hz_fwda,
  output riscv_pkg::fwd_sel_e    o_hz_fwdb,
  output logic                   o_hz_stallpc,
  output logic                   o_hz_stall_fd,
  output logic                   o_hz_flush_fd,
  output logic                   o_hz_flush_de
);
  import riscv_pkg::*;

  logic lwstall;

  // memory stage wins over writeback, x0 never forwards
  function automatic fwd_sel_e fwd_pick(regaddr_t rs, regaddr_t rd_m, logic regw_m,
                                        regaddr_t rd_wb, logic regw_wb);
    fwd_sel_e sel;
    if (regw_m && (rd_m != '0) && (rd_m == rs)) begin
      sel = FWD_MEM;
    end else if (regw_wb && (rd_wb != '0) && (rd_wb == rs)) begin
      sel = FWD_WB;
    end else begin
      sel = FWD_REG;
    end
    return sel;
  endfunction

  assign o_hz_fwda = fwd_pick(i_hz_rs1addr_e, i_hz_rdaddr_m, i_hz_regw_m,
                              i_hz_rdaddr_wb, i_hz_regw_wb);
  assign o_hz_fwdb = fwd_pick(i_hz_rs2addr_e, i_hz_rdaddr_m, i_hz_regw_m,
                              i_hz_rdaddr_wb, i_hz_regw_wb);

  assign lwstall = (i_hz_resultsel_e == RES_MEM) && (i_hz_rdaddr_e != '0) &&
                   ((i_hz_rdaddr_e == i_hz_rs1addr_d) || (i_hz_rdaddr_e == i_hz_rs2addr_d));

  assign o_hz_stallpc  = lwstall;                 // hold fetch one cycle
  assign o_hz_stall_fd = lwstall;
  assign o_hz_flush_fd = i_hz_pcsrc_e;            // wrong-path fetch slot
  assign o_hz_flush_de = i_hz_pcsrc_e | lwstall;  // bubble into execute

endmodule

// ==== riscv_pkg.sv ====
package riscv_pkg;

  parameter int XLEN = 64; // default data width, overridden from the top

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [31:0]     inst_t;
  typedef logic [4:0]      regaddr_t;

  localparam inst_t NOP_INST = 32'h0000_0013; // addi x0, x0, 0

  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_BNE     = 3'b001;
  localparam logic [2:0] F3_DOUBLE  = 3'b011; // ld and sd width code

  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_SLT    = 3'd5,
    ALU_PASS_B = 3'd6  // lui goes straight through
  } alu_op_e;

  typedef enum logic [1:0] {
    RES_ALU = 2'd0,
    RES_MEM = 2'd1,
    RES_PC4 = 2'd2
  } result_sel_e;

  typedef enum logic [1:0] {
    FWD_REG = 2'd0,
    FWD_WB  = 2'd1,
    FWD_MEM = 2'd2
  } fwd_sel_e;

  typedef enum logic [2:0] {
    IMM_I = 3'd0,
    IMM_S = 3'd1,
    IMM_B = 3'd2,
    IMM_U = 3'd3,
    IMM_J = 3'd4
  } imm_sel_e;

endpackage

// ==== riscv_regfile.sv ====
`timescale 1ns/1ns

module riscv_regfile #(
  parameter int XLEN = riscv_pkg::XLEN
) (
  input  logic                i_rf_clk,
  input  logic                i_rst_n,
  input  riscv_pkg::regaddr_t i_rf_rs1addr,
  input  riscv_pkg::regaddr_t i_rf_rs2addr,
  input  logic                i_rf_we,      // from writeback stage
  input  riscv_pkg::regaddr_t i_rf_rdaddr,
  input  logic [XLEN-1:0]     i_rf_rddata,
  output logic [XLEN-1:0]     o_rf_rs1data,
  output logic [XLEN-1:0]     o_rf_rs2data
);

  logic [XLEN-1:0] regs [32];
  logic            wr_valid;

  assign wr_valid = i_rf_we && (i_rf_rdaddr != '0); // x0 stays zero

  always_ff @(posedge i_rf_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_valid) begin
      regs[i_rf_rdaddr] <= i_rf_rddata;
    end
  end

  // same-cycle write shows up on the read port
  assign o_rf_rs1data = (wr_valid && (i_rf_rdaddr == i_rf_rs1addr)) ? i_rf_rddata
                                                                    : regs[i_rf_rs1addr];
  assign o_rf_rs2data = (wr_valid && (i_rf_rdaddr == i_rf_rs2addr)) ? i_rf_rddata
                                                                    : regs[i_rf_rs2addr];

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the riscv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module riscv_core_tb -f riscv_core.f

# exit status of the simulation is the test result
./obj_dir/Vriscv_core_tb
